//--- source/lsu_pkg.sv
// Shared widths, DCCM region constants and packet types for the LSU.
// Every LSU block imports this package.

package lsu_pkg;

   localparam int ADDR_WIDTH       = 32;   // Address and rs1 width
   localparam int DATA_WIDTH       = 32;   // Load/store data and DCCM word
   localparam int OFFSET_WIDTH     = 12;   // Immediate offset
   localparam int BYTES_PER_WORD   = 4;

   //************************************************************
   // DCCM region
   //************************************************************
   localparam logic [ADDR_WIDTH-1:0] DCCM_BASE = 32'hF004_0000;
   localparam int DCCM_ADDR_WIDTH  = 16;   // 64 KB region
   localparam int DCCM_INDEX_WIDTH = 14;   // Word index on the DCCM ports

   //************************************************************
   // Store buffer
   //************************************************************
   localparam int STBUF_DEPTH      = 4;
   localparam int STBUF_PTR_WIDTH  = 2;
   localparam int STBUF_CNT_WIDTH  = 3;

   // Control packet from decode
   typedef struct packed {
      logic valid;
      logic load;
      logic store;
      logic by;       // Byte access
      logic half;     // Halfword access
      logic word;     // Word access
      logic unsign;   // Zero extend the load result
   } lsu_pkt_t;

   typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

endpackage

//--- source/lsu_lsc_ctl.sv
`timescale 1ns/1ps
// Load/store control. Captures the decode packet, forms and checks the
// address in DC1 and carries the packet down to DC5, where a store is
// handed to the store buffer. Also produces the decode stalls and the
// idle and active status.

module lsu_lsc_ctl
   import lsu_pkg::*;
(
   input  logic                        clk,
   input  logic                        reset,
   input  lsu_pkt_t                    lsu_p,
   input  logic [ADDR_WIDTH-1:0]       exu_lsu_rs1_d,
   input  logic [DATA_WIDTH-1:0]       exu_lsu_rs2_d,
   input  logic [OFFSET_WIDTH-1:0]     dec_lsu_offset_d,
   input  logic                        dec_tlu_flush_lower_wb,
   input  logic                        dec_tlu_i0_kill_writeb_wb,
   input  logic [STBUF_CNT_WIDTH-1:0]  stbuf_count,
   output lsu_pkt_t                    pkt_dc1,
   output lsu_pkt_t                    pkt_dc2,
   output lsu_pkt_t                    pkt_dc3,
   output logic [ADDR_WIDTH-1:0]       addr_dc1,
   output logic [ADDR_WIDTH-1:0]       addr_dc2,
   output logic [ADDR_WIDTH-1:0]       addr_dc3,
   output logic                        dccm_rd_req_dc1,
   output logic                        store_commit_dc5,
   output logic [DCCM_INDEX_WIDTH-1:0] store_addr_dc5,
   output logic [DATA_WIDTH-1:0]       store_data_dc5,
   output byte_en_t                    store_byteen_dc5,
   output logic                        lsu_exc_valid_dc3,
   output logic                        lsu_exc_misaligned_dc3,
   output logic [ADDR_WIDTH-1:0]       lsu_exc_addr_dc3,
   output logic                        lsu_store_stall_any,
   output logic                        lsu_load_stall_any,
   output logic                        lsu_idle_any,
   output logic                        lsu_active
);

   lsu_pkt_t                    pkt_q [1:5];
   logic [ADDR_WIDTH-1:0]       addr_q [2:5];
   logic [DATA_WIDTH-1:0]       data_q [2:5];   // Store data already in byte lanes
   logic [5:2]                  fault_q;
   logic [5:1]                  live;           // Valid and not flushed this cycle
   logic [5:1]                  vld;
   logic [5:1]                  st_live;
   logic [ADDR_WIDTH-1:0]       rs1_dc1;
   logic [OFFSET_WIDTH-1:0]     offset_dc1;
   logic [DATA_WIDTH-1:0]       rs2_dc1;
   logic                        in_region_dc1;
   logic                        misal_dc1, misal_dc2, misal_dc3;
   logic                        fault_dc1;
   logic [STBUF_CNT_WIDTH-1:0]  st_inflight;

   //************************************************************
   // DC1 address generation and checks
   //************************************************************
   assign addr_dc1 = rs1_dc1 +
                     {{(ADDR_WIDTH-OFFSET_WIDTH){offset_dc1[OFFSET_WIDTH-1]}}, offset_dc1};
   assign in_region_dc1 = (addr_dc1[ADDR_WIDTH-1:DCCM_ADDR_WIDTH] ==
                           DCCM_BASE[ADDR_WIDTH-1:DCCM_ADDR_WIDTH]);
   assign misal_dc1 = (pkt_q[1].half & addr_dc1[0]) | (pkt_q[1].word & (|addr_dc1[1:0]));
   assign fault_dc1 = ~in_region_dc1 | misal_dc1;

   always_comb begin
      st_inflight = '0;
      for (int i = 1; i <= 5; i++) begin
         vld[i]     = pkt_q[i].valid;
         live[i]    = pkt_q[i].valid & ~dec_tlu_flush_lower_wb;
         st_live[i] = live[i] & pkt_q[i].store;
         st_inflight = st_inflight + {{(STBUF_CNT_WIDTH-1){1'b0}}, st_live[i]};
      end
   end

   // Packets seen by the other blocks exclude faults and flushes
   always_comb begin
      pkt_dc1       = pkt_q[1];
      pkt_dc1.valid = live[1] & ~fault_dc1;
      pkt_dc2       = pkt_q[2];
      pkt_dc2.valid = live[2] & ~fault_q[2];
      pkt_dc3       = pkt_q[3];
      pkt_dc3.valid = live[3] & ~fault_q[3];
   end

   assign dccm_rd_req_dc1 = pkt_dc1.valid & pkt_dc1.load;

   //************************************************************
   // Packet pipeline DC1 to DC5
   //************************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i <= 5; i++) begin
            pkt_q[i] <= '0;
         end
      end else begin
         pkt_q[1] <= lsu_p;
         for (int i = 2; i <= 5; i++) begin
            pkt_q[i]       <= pkt_q[i-1];
            pkt_q[i].valid <= live[i-1];   // Flush drops the packet
         end
      end
   end

   always_ff @(posedge clk) begin
      rs1_dc1    <= exu_lsu_rs1_d;
      offset_dc1 <= dec_lsu_offset_d;
      rs2_dc1    <= exu_lsu_rs2_d;
      addr_q[2]  <= addr_dc1;
      fault_q[2] <= fault_dc1;
      data_q[2]  <= rs2_dc1 << {addr_dc1[1:0], 3'b000};   // Into byte lanes
      misal_dc2  <= misal_dc1;
      misal_dc3  <= misal_dc2;
      for (int i = 3; i <= 5; i++) begin
         addr_q[i]  <= addr_q[i-1];
         fault_q[i] <= fault_q[i-1];
         data_q[i]  <= data_q[i-1];
      end
   end

   assign addr_dc2 = addr_q[2];
   assign addr_dc3 = addr_q[3];

   // Exception packet
   assign lsu_exc_valid_dc3      = live[3] & fault_q[3];
   assign lsu_exc_misaligned_dc3 = misal_dc3;
   assign lsu_exc_addr_dc3       = addr_q[3];

   //************************************************************
   // DC5 store commit
   //************************************************************
   assign store_commit_dc5 = st_live[5] & ~fault_q[5] & ~dec_tlu_i0_kill_writeb_wb;
   assign store_addr_dc5   = addr_q[5][DCCM_ADDR_WIDTH-1:2];
   assign store_data_dc5   = data_q[5];
   assign store_byteen_dc5 = pkt_q[5].by   ? byte_en_t'(4'b0001 << addr_q[5][1:0]) :
                             pkt_q[5].half ? byte_en_t'(4'b0011 << addr_q[5][1:0]) : '1;

   // Stores in flight each need a buffer slot
   assign lsu_store_stall_any = ({1'b0, stbuf_count} + {1'b0, st_inflight}) >= STBUF_DEPTH;
   assign lsu_load_stall_any  = |st_live;
   assign lsu_idle_any        = ~(|vld);
   assign lsu_active          = (|vld) | (stbuf_count != '0);

   // Decode never sends a packet that is both load and store
   a_ld_st_excl: assert property (@(posedge clk) disable iff (reset)
      pkt_q[1].valid |-> !(pkt_q[1].load && pkt_q[1].store));

endmodule

//--- source/lsu_dccm_ctl.sv
`timescale 1ns/1ps
// DCCM port control and load data return. Loads own the read port in
// DC1, the store buffer drains on any other cycle. Read data is merged
// with forwarded store bytes and aligned and extended in DC3.

module lsu_dccm_ctl
   import lsu_pkg::*;
(
   input  logic                        clk,
   input  logic                        reset,
   input  lsu_pkt_t                    pkt_dc1,
   input  lsu_pkt_t                    pkt_dc3,
   input  logic [ADDR_WIDTH-1:0]       addr_dc1,
   input  logic [ADDR_WIDTH-1:0]       addr_dc3,
   input  logic                        dccm_rd_req_dc1,
   input  logic [DATA_WIDTH-1:0]       dccm_rd_data,
   input  logic                        drain_req,
   input  logic [DCCM_INDEX_WIDTH-1:0] drain_addr,
   input  logic [DATA_WIDTH-1:0]       drain_data,
   input  byte_en_t                    drain_byteen,
   input  logic [DATA_WIDTH-1:0]       fwd_data_dc3,
   input  byte_en_t                    fwd_byteen_dc3,
   output logic                        dccm_rden,
   output logic [DCCM_INDEX_WIDTH-1:0] dccm_rd_addr,
   output logic                        dccm_wren,
   output logic [DCCM_INDEX_WIDTH-1:0] dccm_wr_addr,
   output logic [DATA_WIDTH-1:0]       dccm_wr_data,
   output byte_en_t                    dccm_wr_byteen,
   output logic                        drain_ack,
   output logic                        lsu_load_valid_dc3,
   output logic [DATA_WIDTH-1:0]       lsu_result_dc3
);

   logic [DATA_WIDTH-1:0] rd_data_dc3;
   logic [DATA_WIDTH-1:0] merged_dc3;
   logic [DATA_WIDTH-1:0] aligned_dc3;

   //************************************************************
   // DCCM ports
   //************************************************************
   assign dccm_rden      = dccm_rd_req_dc1;
   assign dccm_rd_addr   = addr_dc1[DCCM_ADDR_WIDTH-1:2];
   assign dccm_wren      = drain_req & ~dccm_rd_req_dc1;   // Reads win
   assign dccm_wr_addr   = drain_addr;
   assign dccm_wr_data   = drain_data;
   assign dccm_wr_byteen = drain_byteen;
   assign drain_ack      = dccm_wren;

   // Read data arrives in DC2
   always_ff @(posedge clk) begin
      rd_data_dc3 <= dccm_rd_data;
   end

   //************************************************************
   // DC3 merge, align and extend
   //************************************************************
   always_comb begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         merged_dc3[8*b +: 8] = fwd_byteen_dc3[b] ? fwd_data_dc3[8*b +: 8] :
                                                    rd_data_dc3[8*b +: 8];
      end
      aligned_dc3 = merged_dc3 >> {addr_dc3[1:0], 3'b000};
      if (pkt_dc3.by) begin
         lsu_result_dc3 = {{24{~pkt_dc3.unsign & aligned_dc3[7]}}, aligned_dc3[7:0]};
      end else if (pkt_dc3.half) begin
         lsu_result_dc3 = {{16{~pkt_dc3.unsign & aligned_dc3[15]}}, aligned_dc3[15:0]};
      end else begin
         lsu_result_dc3 = aligned_dc3;
      end
   end

   assign lsu_load_valid_dc3 = pkt_dc3.valid & pkt_dc3.load;

   // A load result in DC3 comes from a DCCM read two cycles before
   a_load_has_read: assert property (@(posedge clk) disable iff (reset)
      lsu_load_valid_dc3 |-> $past(dccm_rden, 2));

   // The read port is only ever opened for a load in DC1
   a_rd_is_load: assert property (@(posedge clk) disable iff (reset)
      dccm_rden |-> (pkt_dc1.valid && pkt_dc1.load));

endmodule

//--- source/lsu_stbuf.sv
`timescale 1ns/1ps
// Store buffer. Committed stores wait here until the DCCM write port is
// free. A load in DC2 picks up matching bytes from the waiting stores,
// newest store winning per byte, and the result is handed to DC3.

module lsu_stbuf
   import lsu_pkg::*;
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        store_commit_dc5,
   input  logic [DCCM_INDEX_WIDTH-1:0] store_addr_dc5,
   input  logic [DATA_WIDTH-1:0]       store_data_dc5,
   input  byte_en_t                    store_byteen_dc5,
   input  logic                        drain_ack,
   input  lsu_pkt_t                    pkt_dc2,
   input  logic [ADDR_WIDTH-1:0]       addr_dc2,
   output logic [STBUF_CNT_WIDTH-1:0]  stbuf_count,
   output logic                        drain_req,
   output logic [DCCM_INDEX_WIDTH-1:0] drain_addr,
   output logic [DATA_WIDTH-1:0]       drain_data,
   output byte_en_t                    drain_byteen,
   output logic [DATA_WIDTH-1:0]       fwd_data_dc3,
   output byte_en_t                    fwd_byteen_dc3
);

   logic [DCCM_INDEX_WIDTH-1:0] ent_addr   [STBUF_DEPTH];
   logic [DATA_WIDTH-1:0]       ent_data   [STBUF_DEPTH];
   byte_en_t                    ent_byteen [STBUF_DEPTH];
   logic [STBUF_PTR_WIDTH-1:0]  wr_ptr, rd_ptr;
   logic [STBUF_CNT_WIDTH-1:0]  count;
   logic                        cmp_en_dc2;
   logic [DATA_WIDTH-1:0]       fwd_data_dc2;
   byte_en_t                    fwd_byteen_dc2;

   //************************************************************
   // Pointers and occupancy
   //************************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (store_commit_dc5) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (drain_ack) begin
            rd_ptr <= rd_ptr + 1'b1;   // Head leaves after its write
         end
         count <= count + {{(STBUF_CNT_WIDTH-1){1'b0}}, store_commit_dc5}
                        - {{(STBUF_CNT_WIDTH-1){1'b0}}, drain_ack};
      end
   end

   // Entry storage
   always_ff @(posedge clk) begin
      if (store_commit_dc5) begin
         ent_addr[wr_ptr]   <= store_addr_dc5;
         ent_data[wr_ptr]   <= store_data_dc5;
         ent_byteen[wr_ptr] <= store_byteen_dc5;
      end
   end

   assign stbuf_count  = count;
   assign drain_req    = (count != '0);
   assign drain_addr   = ent_addr[rd_ptr];
   assign drain_data   = ent_data[rd_ptr];
   assign drain_byteen = ent_byteen[rd_ptr];

   //************************************************************
   // Load forwarding in DC2
   //************************************************************
   assign cmp_en_dc2 = pkt_dc2.valid & pkt_dc2.load;

   // Walk from the head so younger entries overwrite older bytes
   always_comb begin : fwd_merge
      logic [STBUF_PTR_WIDTH-1:0] idx;
      fwd_data_dc2   = '0;
      fwd_byteen_dc2 = '0;
      for (int j = 0; j < STBUF_DEPTH; j++) begin
         idx = rd_ptr + STBUF_PTR_WIDTH'(j);
         if ((j < count) && (ent_addr[idx] == addr_dc2[DCCM_ADDR_WIDTH-1:2])) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
               if (ent_byteen[idx][b]) begin
                  fwd_data_dc2[8*b +: 8] = ent_data[idx][8*b +: 8];
                  fwd_byteen_dc2[b]      = 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      fwd_data_dc3   <= fwd_data_dc2;
      fwd_byteen_dc3 <= cmp_en_dc2 ? fwd_byteen_dc2 : '0;
   end

   // Decode stalls keep the buffer from overflowing
   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      store_commit_dc5 |-> (count < STBUF_DEPTH));

endmodule

//--- source/lsu.sv
`timescale 1ns/1ps
// Load/store unit top level. Connects the pipeline control, the DCCM
// port control and the store buffer. The DCCM itself sits outside.

module lsu
   import lsu_pkg::*;
(
   input  logic                        clk,
   input  logic                        reset,
   // Decode
   input  lsu_pkt_t                    lsu_p,
   input  logic [ADDR_WIDTH-1:0]       exu_lsu_rs1_d,
   input  logic [DATA_WIDTH-1:0]       exu_lsu_rs2_d,
   input  logic [OFFSET_WIDTH-1:0]     dec_lsu_offset_d,
   input  logic                        dec_tlu_flush_lower_wb,
   input  logic                        dec_tlu_i0_kill_writeb_wb,
   // DCCM
   output logic                        dccm_rden,
   output logic [DCCM_INDEX_WIDTH-1:0] dccm_rd_addr,
   input  logic [DATA_WIDTH-1:0]       dccm_rd_data,
   output logic                        dccm_wren,
   output logic [DCCM_INDEX_WIDTH-1:0] dccm_wr_addr,
   output logic [DATA_WIDTH-1:0]       dccm_wr_data,
   output byte_en_t                    dccm_wr_byteen,
   // Results and status
   output logic                        lsu_load_valid_dc3,
   output logic [DATA_WIDTH-1:0]       lsu_result_dc3,
   output logic                        lsu_exc_valid_dc3,
   output logic                        lsu_exc_misaligned_dc3,
   output logic [ADDR_WIDTH-1:0]       lsu_exc_addr_dc3,
   output logic                        lsu_store_stall_any,
   output logic                        lsu_load_stall_any,
   output logic                        lsu_idle_any,
   output logic                        lsu_active
);

   lsu_pkt_t                    pkt_dc1, pkt_dc2, pkt_dc3;
   logic [ADDR_WIDTH-1:0]       addr_dc1, addr_dc2, addr_dc3;
   logic                        dccm_rd_req_dc1;
   logic                        store_commit_dc5;
   logic [DCCM_INDEX_WIDTH-1:0] store_addr_dc5;
   logic [DATA_WIDTH-1:0]       store_data_dc5;
   byte_en_t                    store_byteen_dc5;
   logic [STBUF_CNT_WIDTH-1:0]  stbuf_count;
   logic                        drain_req, drain_ack;
   logic [DCCM_INDEX_WIDTH-1:0] drain_addr;
   logic [DATA_WIDTH-1:0]       drain_data;
   byte_en_t                    drain_byteen;
   logic [DATA_WIDTH-1:0]       fwd_data_dc3;
   byte_en_t                    fwd_byteen_dc3;

   lsu_lsc_ctl  lsc_ctl  (.*);   // Pipeline, checks and stalls

   lsu_dccm_ctl dccm_ctl (.*);   // DCCM ports and load return

   lsu_stbuf    stbuf    (.*);   // Committed stores and forwarding

endmodule

//--- verification/lsu_tb.sv
`timescale 1ns/1ps
// Testbench for the load/store unit. Holds the DCCM memory, an
// architectural memory and a stage-accurate model of the DC1 to DC5
// pipeline, drives random loads and stores on the falling edge and checks
// every DC3 result, exception, stall and status output against the model.

module lsu_tb import lsu_pkg::*; ();

   logic                        clk, reset;
   lsu_pkt_t                    lsu_p;
   logic [ADDR_WIDTH-1:0]       exu_lsu_rs1_d;
   logic [DATA_WIDTH-1:0]       exu_lsu_rs2_d;
   logic [OFFSET_WIDTH-1:0]     dec_lsu_offset_d;
   logic                        dec_tlu_flush_lower_wb, dec_tlu_i0_kill_writeb_wb;
   logic                        dccm_rden, dccm_wren;
   logic [DCCM_INDEX_WIDTH-1:0] dccm_rd_addr, dccm_wr_addr;
   logic [DATA_WIDTH-1:0]       dccm_rd_data, dccm_wr_data;
   byte_en_t                    dccm_wr_byteen;
   logic                        lsu_load_valid_dc3, lsu_exc_valid_dc3, lsu_exc_misaligned_dc3;
   logic [DATA_WIDTH-1:0]       lsu_result_dc3;
   logic [ADDR_WIDTH-1:0]       lsu_exc_addr_dc3;
   logic                        lsu_store_stall_any, lsu_load_stall_any;
   logic                        lsu_idle_any, lsu_active;

   logic [31:0] dccm_mem [0:16383];
   logic [31:0] arch_mem [0:16383];
   logic        s_v [1:5], s_ld [1:5], s_st [1:5], s_fault [1:5], s_mis [1:5];
   logic [1:0]  s_sz [1:5];                   // 0 byte, 1 half, 2 word
   logic [31:0] s_addr [1:5], s_data [1:5], s_exp [1:5];
   logic [15:0] lfsr;
   logic        flush_on, kill_on;
   int          model_cnt, errors, checks, test_err;

   lsu dut (.*);

   always #20 clk = ~clk;

   // DCCM with byte enables and a one-cycle read
   always @(posedge clk) begin
      if (dccm_wren) begin
         for (int b = 0; b < 4; b++) begin
            if (dccm_wr_byteen[b]) dccm_mem[dccm_wr_addr][8*b +: 8] <= dccm_wr_data[8*b +: 8];
         end
      end
      if (dccm_rden) dccm_rd_data <= dccm_mem[dccm_rd_addr];
   end

   // Fibonacci LFSR, taps 16 14 13 11, one step per bit
   function automatic logic [31:0] rnd(input int n);
      logic        fb;
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   //************************************************************
   // One clock cycle: drive, check, then advance the model
   //************************************************************
   task automatic step(input logic v, ld, st, input logic [1:0] sz, input logic un,
                       input logic [31:0] a, data, output logic issued);
      logic [31:0] off, w, sh;
      logic [3:0]  be;
      logic        flush, kill, st_stall, ld_stall, rd, any_v, ok;
      int          inflight;
      @(negedge clk);
      flush = flush_on && (rnd(3) == 0);
      kill  = kill_on && (rnd(3) == 0);
      inflight = 0;
      any_v = 1'b0;
      for (int i = 1; i <= 5; i++) begin
         if (s_v[i] && s_st[i] && !flush) inflight++;
         any_v = any_v | s_v[i];
      end
      st_stall = (model_cnt + inflight) >= STBUF_DEPTH;
      ld_stall = inflight > 0;
      ok = v && !(ld && ld_stall) && !(st && st_stall);   // Decode holds back
      off = rnd(12);
      lsu_p = '{ok, ld, st, sz == 2'd0, sz == 2'd1, sz == 2'd2, un};
      exu_lsu_rs1_d = a - {{20{off[11]}}, off[11:0]};
      exu_lsu_rs2_d = data;
      dec_lsu_offset_d = off[11:0];
      dec_tlu_flush_lower_wb = flush;
      dec_tlu_i0_kill_writeb_wb = kill;
      #10;
      check("lsu_store_stall_any", 32'(lsu_store_stall_any), 32'(st_stall));
      check("lsu_load_stall_any", 32'(lsu_load_stall_any), 32'(ld_stall));
      check("lsu_idle_any", 32'(lsu_idle_any), 32'(!any_v));
      check("lsu_active", 32'(lsu_active), 32'(any_v || model_cnt != 0));
      rd = s_v[1] && s_ld[1] && !s_fault[1] && !flush;
      check("dccm_rden", 32'(dccm_rden), 32'(rd));
      check("dccm_wren", 32'(dccm_wren), 32'(model_cnt > 0 && !rd));
      if (s_v[3] && !flush && s_fault[3]) begin
         check("lsu_exc_valid_dc3", 32'(lsu_exc_valid_dc3), 32'd1);
         check("lsu_exc_misaligned_dc3", 32'(lsu_exc_misaligned_dc3), 32'(s_mis[3]));
         check("lsu_exc_addr_dc3", lsu_exc_addr_dc3, s_addr[3]);
         check("lsu_load_valid_dc3", 32'(lsu_load_valid_dc3), 32'd0);
      end else begin
         check("lsu_exc_valid_dc3", 32'(lsu_exc_valid_dc3), 32'd0);
         check("lsu_load_valid_dc3", 32'(lsu_load_valid_dc3),
               32'(s_v[3] && s_ld[3] && !flush));
         if (s_v[3] && s_ld[3] && !flush) check("lsu_result_dc3", lsu_result_dc3, s_exp[3]);
      end
      // Drain when the read port is free, commit the DC5 store
      if (model_cnt > 0 && !rd) model_cnt--;
      if (s_v[5] && s_st[5] && !s_fault[5] && !flush && !kill) begin
         be = (s_sz[5] == 2'd0) ? 4'b0001 << s_addr[5][1:0] :
              (s_sz[5] == 2'd1) ? 4'b0011 << s_addr[5][1:0] : 4'b1111;
         sh = s_data[5] << {s_addr[5][1:0], 3'b000};
         for (int b = 0; b < 4; b++) begin
            if (be[b]) arch_mem[s_addr[5][15:2]][8*b +: 8] = sh[8*b +: 8];
         end
         model_cnt++;
      end
      for (int i = 5; i >= 2; i--) begin
         s_v[i] = s_v[i-1] && !flush;
         s_ld[i] = s_ld[i-1];
         s_st[i] = s_st[i-1];
         s_sz[i] = s_sz[i-1];
         s_addr[i] = s_addr[i-1];
         s_data[i] = s_data[i-1];
         s_exp[i] = s_exp[i-1];
         s_fault[i] = s_fault[i-1];
         s_mis[i] = s_mis[i-1];
      end
      s_v[1] = ok;
      s_ld[1] = ld;
      s_st[1] = st;
      s_sz[1] = sz;
      s_addr[1] = a;
      s_data[1] = data;
      s_mis[1] = (sz == 2'd1 && a[0]) || (sz == 2'd2 && a[1:0] != 2'b00);
      s_fault[1] = s_mis[1] || (a[31:16] != DCCM_BASE[31:16]);
      w = arch_mem[a[15:2]] >> {a[1:0], 3'b000};   // Expected value at issue
      if (sz == 2'd0) s_exp[1] = {{24{!un & w[7]}}, w[7:0]};
      else if (sz == 2'd1) s_exp[1] = {{16{!un & w[15]}}, w[15:0]};
      else s_exp[1] = w;
      issued = ok;
   endtask

   task automatic issue(input logic ld, st, input logic [1:0] sz, input logic un,
                        input logic [31:0] a, data);
      logic done;
      int   n;
      done = 1'b0;
      n = 0;
      while (!done && n < 50) begin
         step(1'b1, ld, st, sz, un, a, data, done);
         n++;
      end
      if (!done) begin
         errors++;
         $display("Timeout: decode stall never released at %0t ns", $time);
      end
   endtask

   task automatic wait_idle();
      logic dummy;
      int   n;
      step(1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 32'd0, 32'd0, dummy);   // Last op is now in DC1
      n = 1;
      while ((lsu_active || model_cnt != 0) && n < 200) begin
         step(1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 32'd0, 32'd0, dummy);
         n++;
      end
      if (lsu_active || model_cnt != 0) begin
         errors++;
         $display("Timeout: lsu_active did not fall at %0t ns", $time);
      end
   endtask

   task automatic random_op(input logic allow_bad, input logic allow_st);
      logic [1:0]  sz;
      logic [31:0] a;
      logic        st;
      sz = 2'(rnd(2));
      if (sz == 2'd3) sz = 2'd2;
      a = DCCM_BASE | (rnd(4) << 2);               // Small window for hits
      if (sz == 2'd0) a[1:0] = 2'(rnd(2));
      else if (sz == 2'd1) a[1] = rnd(1) != 0;
      if (allow_bad && rnd(3) == 0) begin
         if (rnd(1) != 0) begin
            a = a ^ 32'h0100_0000;                 // Outside the region
         end else begin
            sz = 2'd2;
            a[0] = 1'b1;
         end
      end
      st = allow_st && (rnd(1) != 0);
      issue(!st, st, sz, rnd(1) != 0, a, rnd(32));
   endtask

   task automatic compare_mem();
      for (int i = 0; i < 16384; i++) begin
         if (dccm_mem[i] !== arch_mem[i]) check($sformatf("dccm_mem[%0d]", i),
                                                dccm_mem[i], arch_mem[i]);
      end
   endtask

   task automatic end_test(input string name);
      $display("test %s done with %0d new errors", name, errors - test_err);
      test_err = errors;
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      lsu_p = '0;
      exu_lsu_rs1_d = '0;
      exu_lsu_rs2_d = '0;
      dec_lsu_offset_d = '0;
      dec_tlu_flush_lower_wb = 1'b0;
      dec_tlu_i0_kill_writeb_wb = 1'b0;
      dccm_rd_data = '0;
      lfsr = 16'd24;
      flush_on = 1'b0;
      kill_on = 1'b0;
      model_cnt = 0;
      errors = 0;
      checks = 0;
      test_err = 0;
      for (int i = 0; i < 16384; i++) begin
         arch_mem[i] = {i[13:0], 2'b10, ~i[13:0], 2'b01};   // Unique per word
         dccm_mem[i] = arch_mem[i];
      end
      for (int i = 1; i <= 5; i++) s_v[i] = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      #10;
      check("dccm_rden", 32'(dccm_rden), 32'd0);
      check("dccm_wren", 32'(dccm_wren), 32'd0);
      check("lsu_load_valid_dc3", 32'(lsu_load_valid_dc3), 32'd0);
      check("lsu_exc_valid_dc3", 32'(lsu_exc_valid_dc3), 32'd0);
      check("lsu_store_stall_any", 32'(lsu_store_stall_any), 32'd0);
      check("lsu_load_stall_any", 32'(lsu_load_stall_any), 32'd0);
      check("lsu_active", 32'(lsu_active), 32'd0);
      check("lsu_idle_any", 32'(lsu_idle_any), 32'd1);
      end_test("reset");

      for (int i = 0; i < 60; i++) random_op(1'b0, 1'b0);
      wait_idle();
      end_test("random loads");

      // Two stores into one word, then loads of the merged bytes
      issue(1'b0, 1'b1, 2'd2, 1'b0, DCCM_BASE + 32'h14, 32'h1122_3344);
      issue(1'b0, 1'b1, 2'd0, 1'b0, DCCM_BASE + 32'h16, 32'h0000_00AB);
      issue(1'b1, 1'b0, 2'd2, 1'b0, DCCM_BASE + 32'h14, 32'd0);
      issue(1'b1, 1'b0, 2'd1, 1'b0, DCCM_BASE + 32'h16, 32'd0);
      issue(1'b1, 1'b0, 2'd0, 1'b1, DCCM_BASE + 32'h16, 32'd0);
      issue(1'b1, 1'b0, 2'd1, 1'b1, DCCM_BASE + 32'h14, 32'd0);
      wait_idle();
      issue(1'b1, 1'b0, 2'd2, 1'b0, DCCM_BASE + 32'h14, 32'd0);
      wait_idle();
      end_test("store forwarding");

      for (int i = 0; i < 40; i++) random_op(1'b1, 1'b1);
      issue(1'b0, 1'b1, 2'd2, 1'b0, DCCM_BASE + 32'h0001_0000, 32'hDEAD_BEEF);
      issue(1'b1, 1'b0, 2'd1, 1'b0, DCCM_BASE + 32'h3, 32'd0);
      wait_idle();
      compare_mem();
      end_test("exceptions");

      flush_on = 1'b1;
      kill_on = 1'b1;
      for (int i = 0; i < 80; i++) random_op(1'b0, 1'b1);
      flush_on = 1'b0;
      kill_on = 1'b0;
      wait_idle();
      compare_mem();
      end_test("flush and kill");

      for (int i = 0; i < 300; i++) random_op(1'b1, 1'b1);
      wait_idle();
      compare_mem();
      end_test("long random mix");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- tb.f
source/lsu_pkg.sv
source/lsu_lsc_ctl.sv
source/lsu_dccm_ctl.sv
source/lsu_stbuf.sv
source/lsu.sv
verification/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator

verilator --binary --timing -Wno-fatal --top-module lsu_tb -f tb.f -o lsu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build error"
   exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulator exited with status $status"
   exit 1
fi

if grep -q "^Test passed$" sim.log; then
   exit 0
fi
exit 1
